/* etx_arbiter.sv */
module etx_arbiter
   (
   input  logic                      sys_clk,
   input  logic                      sys_nreset,
   input  logic                      etx_nreset,
   input  logic                      tx_active,
   input  logic                      wr_strobe,
   input  etx_pkt_pkg::etx_pkt_t     wr_pkt,
   input  logic                      rr_strobe,
   input  etx_pkt_pkg::etx_pkt_t     rr_pkt,
   input  logic                      ser_idle,
   output logic                      load,
   output etx_pkt_pkg::etx_pkt_t     load_pkt,
   output etx_ctrl_pkg::etx_status_t status
   );

   etx_pkt_pkg::etx_pkt_t wr_slot;
   etx_pkt_pkg::etx_pkt_t rr_slot;
   logic                  wr_full;
   logic                  rr_full;
   logic                  wr_take;
   logic                  rr_take;
   logic                  grant_wr;
   logic                  last_wr;   // write port won the last grant

   // strobes only count while the link is up
   assign wr_take = tx_active & wr_strobe & ~wr_full;
   assign rr_take = tx_active & rr_strobe & ~rr_full;

   //########################################
   // round-robin grant
   //########################################

   assign grant_wr = wr_full & (~rr_full | ~last_wr);
   assign load     = ser_idle & (wr_full | rr_full);
   assign load_pkt = grant_wr ? wr_slot : rr_slot;

   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
      begin
         wr_full <= 1'b0;
         rr_full <= 1'b0;
         last_wr <= 1'b0;        // write wins the first tie
         status  <= '0;
      end
      else if (!etx_nreset)
      begin
         wr_full <= 1'b0;
         rr_full <= 1'b0;
         last_wr <= 1'b0;
         status  <= '0;
      end
      else
      begin
         if (wr_take)                wr_full <= 1'b1;
         else if (load && grant_wr)  wr_full <= 1'b0;
         if (rr_take)                rr_full <= 1'b1;
         else if (load && !grant_wr) rr_full <= 1'b0;
         if (load) last_wr <= grant_wr;
         // strobe on a full slot is dropped and flagged until core reset
         if (tx_active && wr_strobe && wr_full) status.wr_overflow <= 1'b1;
         if (tx_active && rr_strobe && rr_full) status.rr_overflow <= 1'b1;
      end
   end

   // one pending packet per port
   always_ff @(posedge sys_clk)
   begin
      if (wr_take) wr_slot <= wr_pkt;
      if (rr_take) rr_slot <= rr_pkt;
   end

endmodule

/* etx_config.svh */
`ifndef ETX_CONFIG_SVH
`define ETX_CONFIG_SVH

//########################################
// packet field widths
//########################################

`define ETX_CTRL_W 8   // control field
`define ETX_ADDR_W 32  // address field
`define ETX_DATA_W 32  // data field
`define ETX_LANE_W 8   // one byte per lane beat

//########################################
// reset sequencer pacing
//########################################

`define ETX_RCW 4      // heartbeat every 16 cycles in sim

`endif

/* etx_ctrl_pkg.sv */
package etx_ctrl_pkg;

   // reset sequencer states
   typedef enum logic [2:0] {
      RST_ALL      = 3'd0,  // everything held
      START_PLL    = 3'd1,  // pll running, wait for lock
      STOP_PLL     = 3'd2,
      DEASSERT_RST = 3'd3,  // remote chip out of reset
      HOLD         = 3'd4,  // wait for relock
      ACTIVE       = 3'd5
   } etx_rst_state_t;

   // sticky drop flags, one per peer port
   typedef struct packed {
      logic wr_overflow;
      logic rr_overflow;
   } etx_status_t;

endpackage

/* etx_pkt_pkg.sv */
`include "etx_config.svh"

package etx_pkt_pkg;

   // packet fields
   typedef logic [`ETX_CTRL_W-1:0] etx_ctrl_t;
   typedef logic [`ETX_ADDR_W-1:0] etx_addr_t;
   typedef logic [`ETX_DATA_W-1:0] etx_data_t;

   // one byte on the transmit lane
   typedef logic [`ETX_LANE_W-1:0] etx_lane_t;

   // ctrl sits at the top and goes out first
   typedef struct packed {
      etx_ctrl_t ctrl;
      etx_addr_t addr;
      etx_data_t data;
   } etx_pkt_t;

   // lane beats per packet
   localparam int ETX_BEATS =
      (`ETX_CTRL_W + `ETX_ADDR_W + `ETX_DATA_W) / `ETX_LANE_W;

endpackage

/* etx_reset_seq.sv */
`include "etx_config.svh"

module etx_reset_seq
  #(
   parameter int RCW = `ETX_RCW   // heartbeat counter width
   )
   (
   input  logic sys_clk,
   input  logic sys_nreset,
   input  logic soft_reset,    // level, from software
   input  logic pll_locked,    // async to sys_clk
   output logic pll_reset,
   output logic chip_nreset,
   output logic tx_active,
   output logic etx_nreset     // core reset, synced
   );

   logic [RCW-1:0]              hb_cnt;
   logic                        heartbeat;
   logic                        lock_meta;
   logic                        lock_sync;
   logic [1:0]                  core_sync;
   etx_ctrl_pkg::etx_rst_state_t state;

   //########################################
   // heartbeat and lock sync
   //########################################

   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
      begin
         hb_cnt    <= '0;
         heartbeat <= 1'b0;
         lock_meta <= 1'b0;
         lock_sync <= 1'b0;
      end
      else
      begin
         hb_cnt    <= hb_cnt + 1'b1;
         heartbeat <= ~(|hb_cnt);   // one pulse per wrap
         lock_meta <= pll_locked;
         lock_sync <= lock_meta;
      end
   end

   //########################################
   // reset sequence FSM
   //########################################

   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
         state <= etx_ctrl_pkg::RST_ALL;
      else if (heartbeat)
      begin
         case (state)
            etx_ctrl_pkg::RST_ALL:
               if (!soft_reset) state <= etx_ctrl_pkg::START_PLL;
            etx_ctrl_pkg::START_PLL:
               if (lock_sync) state <= etx_ctrl_pkg::STOP_PLL;
            etx_ctrl_pkg::STOP_PLL:
               state <= etx_ctrl_pkg::DEASSERT_RST;
            etx_ctrl_pkg::DEASSERT_RST:
               state <= etx_ctrl_pkg::HOLD;
            etx_ctrl_pkg::HOLD:
               if (lock_sync) state <= etx_ctrl_pkg::ACTIVE;
            etx_ctrl_pkg::ACTIVE:
               if (soft_reset) state <= etx_ctrl_pkg::RST_ALL;
            default:
               state <= etx_ctrl_pkg::RST_ALL;
         endcase
      end
   end

   // reset outputs decoded from state
   always_comb
   begin
      pll_reset   = 1'b1;
      chip_nreset = 1'b0;
      tx_active   = 1'b0;
      case (state)
         etx_ctrl_pkg::START_PLL:    pll_reset = 1'b0;
         etx_ctrl_pkg::DEASSERT_RST: chip_nreset = 1'b1;
         etx_ctrl_pkg::HOLD:
         begin
            pll_reset   = 1'b0;
            chip_nreset = 1'b1;
         end
         etx_ctrl_pkg::ACTIVE:
         begin
            pll_reset   = 1'b0;
            chip_nreset = 1'b1;
            tx_active   = 1'b1;
         end
         default: ;                   // RST_ALL, STOP_PLL hold defaults
      endcase
   end

   // core reset asserts at once and releases two cycles late
   always_ff @(posedge sys_clk or negedge tx_active)
   begin
      if (!tx_active)
         core_sync <= 2'b00;
      else
         core_sync <= {core_sync[0], 1'b1};
   end

   assign etx_nreset = core_sync[1];

endmodule

/* etx_serializer.sv */
module etx_serializer
   (
   input  logic                      sys_clk,
   input  logic                      sys_nreset,
   input  logic                      etx_nreset,
   input  logic                      load,
   input  etx_pkt_pkg::etx_pkt_t     load_pkt,
   output logic                      ser_idle,
   output logic                      tx_frame,
   output etx_pkt_pkg::etx_lane_t    tx_data
   );

   localparam int PKT_W  = $bits(etx_pkt_pkg::etx_pkt_t);
   localparam int LANE_W = $bits(etx_pkt_pkg::etx_lane_t);
   localparam int CNT_W  = $clog2(etx_pkt_pkg::ETX_BEATS + 1);

   logic [PKT_W-1:0] shift_q;   // top byte is on the lane
   logic [CNT_W-1:0] beats_left;

   //########################################
   // frame control
   //########################################

   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
      begin
         tx_frame   <= 1'b0;
         beats_left <= '0;
      end
      else if (!etx_nreset)
      begin
         tx_frame   <= 1'b0;
         beats_left <= '0;
      end
      else if (load)
      begin
         tx_frame   <= 1'b1;
         beats_left <= CNT_W'(etx_pkt_pkg::ETX_BEATS);
      end
      else if (tx_frame)
      begin
         beats_left <= beats_left - 1'b1;
         tx_frame   <= (beats_left != CNT_W'(1));   // last beat on the lane
      end
   end

   //########################################
   // byte shifter
   //########################################

   always_ff @(posedge sys_clk)
   begin
      if (load)
         shift_q <= load_pkt;
      else if (tx_frame)
         shift_q <= shift_q << LANE_W;   // next byte moves up
   end

   assign tx_data  = shift_q[PKT_W-1 -: LANE_W];
   assign ser_idle = ~tx_frame;   // gap cycle between frames

endmodule

/* etx_top.sv */
`include "etx_config.svh"

module etx_top
   (
   input  logic                      sys_clk,
   input  logic                      sys_nreset,
   input  logic                      soft_reset,
   input  logic                      pll_locked,
   output logic                      pll_reset,
   output logic                      chip_nreset,
   output logic                      tx_active,
   input  logic                      wr_strobe,
   input  etx_pkt_pkg::etx_pkt_t     wr_pkt,
   input  logic                      rr_strobe,
   input  etx_pkt_pkg::etx_pkt_t     rr_pkt,
   output logic                      tx_frame,
   output etx_pkt_pkg::etx_lane_t    tx_data,
   output etx_ctrl_pkg::etx_status_t status
   );

   logic                  etx_nreset;
   logic                  ser_idle;
   logic                  load;
   etx_pkt_pkg::etx_pkt_t load_pkt;

   etx_reset_seq #(.RCW(`ETX_RCW)) reset_seq_i (
      .sys_clk     (sys_clk),
      .sys_nreset  (sys_nreset),
      .soft_reset  (soft_reset),
      .pll_locked  (pll_locked),
      .pll_reset   (pll_reset),
      .chip_nreset (chip_nreset),
      .tx_active   (tx_active),
      .etx_nreset  (etx_nreset));

   // two peers, one lane
   etx_arbiter arbiter_i (
      .sys_clk     (sys_clk),
      .sys_nreset  (sys_nreset),
      .etx_nreset  (etx_nreset),
      .tx_active   (tx_active),
      .wr_strobe   (wr_strobe),
      .wr_pkt      (wr_pkt),
      .rr_strobe   (rr_strobe),
      .rr_pkt      (rr_pkt),
      .ser_idle    (ser_idle),
      .load        (load),
      .load_pkt    (load_pkt),
      .status      (status));

   etx_serializer serializer_i (
      .sys_clk     (sys_clk),
      .sys_nreset  (sys_nreset),
      .etx_nreset  (etx_nreset),
      .load        (load),
      .load_pkt    (load_pkt),
      .ser_idle    (ser_idle),
      .tx_frame    (tx_frame),
      .tx_data     (tx_data));

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -Wno-fatal --top-module tb_etx_top -f src.f -o sim_etx \
   || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_etx > sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "simulation reported failure"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0

/* src.f */
+incdir+.
etx_pkt_pkg.sv
etx_ctrl_pkg.sv
etx_reset_seq.sv
etx_arbiter.sv
etx_serializer.sv
etx_top.sv
tb_etx_top.sv

/* tb_etx_top.sv */
`include "etx_config.svh"

module tb_etx_top;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_HALF      = 20;
   localparam int BEATS         = etx_pkt_pkg::ETX_BEATS;
   localparam int PKT_W         = $bits(etx_pkt_pkg::etx_pkt_t);
   localparam int LANE_W        = $bits(etx_pkt_pkg::etx_lane_t);
   localparam int HB_CYCLES     = 1 << `ETX_RCW;
   localparam int LOCK_DELAY    = 20;              // pll lock after reset release
   localparam int FRAME_TIMEOUT = 40;
   localparam int LINK_TIMEOUT  = 40 * HB_CYCLES;

   // {pll_reset, chip_nreset, tx_active} for each sequencer state in order
   localparam logic [2:0] SEQ_OUT [0:5] =
      '{3'b100, 3'b000, 3'b100, 3'b110, 3'b010, 3'b011};

   logic                      sys_clk;
   logic                      sys_nreset;
   logic                      soft_reset;
   logic                      pll_locked;
   logic                      pll_reset;
   logic                      chip_nreset;
   logic                      tx_active;
   logic                      wr_strobe;
   etx_pkt_pkg::etx_pkt_t     wr_pkt;
   logic                      rr_strobe;
   etx_pkt_pkg::etx_pkt_t     rr_pkt;
   logic                      tx_frame;
   etx_pkt_pkg::etx_lane_t    tx_data;
   etx_ctrl_pkg::etx_status_t status;

   logic   lock_hold;            // keeps the pll unlocked
   logic   model_lock = 1'b0;
   int     lock_cnt;
   integer seed;
   int     value_errors;
   int     timeout_errors;
   int     other_errors;
   int     seq_idx;              // sequencer state reached so far
   logic   last_wr;              // expected round-robin pointer

   always #CLK_HALF sys_clk = ~sys_clk;

   //########################################
   // pll model and DUT
   //########################################

   always @(negedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
      begin
         model_lock <= 1'b0;
         lock_cnt   <= 0;
      end
      else if (pll_reset)
      begin
         model_lock <= 1'b0;   // lock lost while in reset
         lock_cnt   <= 0;
      end
      else if (lock_cnt < LOCK_DELAY - 1)
         lock_cnt <= lock_cnt + 1;
      else
         model_lock <= 1'b1;
   end

   assign pll_locked = model_lock & ~lock_hold;

   etx_top dut_i (
      .sys_clk     (sys_clk),
      .sys_nreset  (sys_nreset),
      .soft_reset  (soft_reset),
      .pll_locked  (pll_locked),
      .pll_reset   (pll_reset),
      .chip_nreset (chip_nreset),
      .tx_active   (tx_active),
      .wr_strobe   (wr_strobe),
      .wr_pkt      (wr_pkt),
      .rr_strobe   (rr_strobe),
      .rr_pkt      (rr_pkt),
      .tx_frame    (tx_frame),
      .tx_data     (tx_data),
      .status      (status));

   //########################################
   // compare tasks
   //########################################

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_lane(input string name, input etx_pkt_pkg::etx_lane_t got,
                             input etx_pkt_pkg::etx_lane_t exp);
      if (got !== exp)
      begin
         $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_status(input string name, input etx_ctrl_pkg::etx_status_t got,
                               input etx_ctrl_pkg::etx_status_t exp);
      if (got !== exp)
      begin
         $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_pkt(input string name, input etx_pkt_pkg::etx_pkt_t got,
                            input etx_pkt_pkg::etx_pkt_t exp);
      if (got !== exp)
      begin
         $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
         value_errors++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout at %0t while waiting for %s", $time, what);
      timeout_errors++;
   endtask

   //########################################
   // helpers
   //########################################

   function automatic etx_pkt_pkg::etx_pkt_t random_pkt();
      etx_pkt_pkg::etx_pkt_t p;
      p.ctrl = etx_pkt_pkg::etx_ctrl_t'($random(seed));
      p.addr = etx_pkt_pkg::etx_addr_t'($random(seed));
      p.data = etx_pkt_pkg::etx_data_t'($random(seed));
      return p;
   endfunction

   // one-cycle strobes driven from a falling edge
   task automatic strobe_ports(input logic do_wr, input etx_pkt_pkg::etx_pkt_t wp,
                               input logic do_rr, input etx_pkt_pkg::etx_pkt_t rp);
      wr_strobe = do_wr;
      wr_pkt    = wp;
      rr_strobe = do_rr;
      rr_pkt    = rp;
      @(negedge sys_clk);
      wr_strobe = 1'b0;
      rr_strobe = 1'b0;
   endtask

   task automatic wait_active(input logic level, input int limit, input string what);
      int n;
      n = 0;
      while (tx_active !== level && n < limit)
      begin
         @(negedge sys_clk);
         n++;
      end
      if (tx_active !== level)
         report_timeout(what);
   endtask

   // etx_nreset trails tx_active through two flops
   task automatic settle_core_reset();
      repeat (3) @(negedge sys_clk);
   endtask

   task automatic follow_sequence();
      logic [2:0] now;
      now = {pll_reset, chip_nreset, tx_active};
      if (now !== SEQ_OUT[seq_idx])
      begin
         if (seq_idx == 5)
         begin
            $display("sequencer outputs changed after reaching active at %0t", $time);
            other_errors++;
         end
         else
         begin
            seq_idx++;
            check_bit("pll_reset", pll_reset, SEQ_OUT[seq_idx][2]);
            check_bit("chip_nreset", chip_nreset, SEQ_OUT[seq_idx][1]);
            check_bit("tx_active", tx_active, SEQ_OUT[seq_idx][0]);
         end
      end
   endtask

   task automatic collect_frame(output etx_pkt_pkg::etx_pkt_t pkt, output logic got);
      logic [PKT_W-1:0] acc;
      int               n;
      acc = '0;
      got = 1'b0;
      n   = 0;
      while (!tx_frame && n < FRAME_TIMEOUT)
      begin
         @(negedge sys_clk);
         n++;
      end
      pkt = acc;
      if (!tx_frame)
      begin
         report_timeout("tx_frame");
         return;
      end
      for (n = 0; n < BEATS; n++)
      begin
         if (!tx_frame)
         begin
            $display("frame ended early after %0d beats at %0t", n, $time);
            other_errors++;
            return;
         end
         acc = {acc[PKT_W-LANE_W-1:0], tx_data};   // msb first
         @(negedge sys_clk);
      end
      check_bit("tx_frame", tx_frame, 1'b0);          // no tenth beat
      pkt = acc;
      got = 1'b1;
   endtask

   task automatic expect_frame(input etx_pkt_pkg::etx_pkt_t exp, input string name);
      etx_pkt_pkg::etx_pkt_t pkt;
      logic                  got;
      collect_frame(pkt, got);
      if (got)
         check_pkt(name, pkt, exp);
   endtask

   task automatic expect_no_frame(input int cycles);
      int   n;
      logic seen;
      seen = 1'b0;
      for (n = 0; n < cycles; n++)
      begin
         if (tx_frame)
            seen = 1'b1;
         @(negedge sys_clk);
      end
      if (seen)
      begin
         $display("unexpected frame on the lane before %0t", $time);
         other_errors++;
      end
   endtask

   task automatic send_single(input logic is_wr);
      etx_pkt_pkg::etx_pkt_t p;
      etx_pkt_pkg::etx_pkt_t other;
      p     = random_pkt();
      other = ~p;                // idle port carries a different packet
      if (is_wr)
         strobe_ports(1'b1, p, 1'b0, other);
      else
         strobe_ports(1'b0, other, 1'b1, p);
      expect_frame(p, is_wr ? "wr frame" : "rr frame");
      last_wr = is_wr;
   endtask

   // tie goes to the port not granted last and the other follows
   task automatic send_pair();
      etx_pkt_pkg::etx_pkt_t wp;
      etx_pkt_pkg::etx_pkt_t rp;
      wp = random_pkt();
      rp = random_pkt();
      strobe_ports(1'b1, wp, 1'b1, rp);
      if (last_wr)
      begin
         expect_frame(rp, "rr frame of pair");
         expect_frame(wp, "wr frame of pair");
      end
      else
      begin
         expect_frame(wp, "wr frame of pair");
         expect_frame(rp, "rr frame of pair");
      end
   endtask

   //########################################
   // directed tests
   //########################################

   task automatic test_link_up();
      int   n;
      logic rose;
      check_bit("pll_reset", pll_reset, 1'b1);       // still in reset here
      check_bit("chip_nreset", chip_nreset, 1'b0);
      check_bit("tx_active", tx_active, 1'b0);
      check_bit("tx_frame", tx_frame, 1'b0);
      check_status("status", status, '0);
      sys_nreset = 1'b1;
      rose       = 1'b0;
      for (n = 0; n < 8 * HB_CYCLES; n++)
      begin
         follow_sequence();
         if (tx_active)
            rose = 1'b1;
         @(negedge sys_clk);
      end
      if (rose || seq_idx != 1)
      begin
         $display("sequencer went past pll start without lock at %0t", $time);
         other_errors++;
      end
      lock_hold = 1'b0;
      n         = 0;
      while (seq_idx < 5 && n < LINK_TIMEOUT)
      begin
         follow_sequence();
         @(negedge sys_clk);
         n++;
      end
      if (seq_idx < 5)
         report_timeout("link to become active");
      settle_core_reset();
   endtask

   task automatic test_single_write();
      etx_pkt_pkg::etx_pkt_t p;
      p = random_pkt();
      strobe_ports(1'b1, p, 1'b0, '0);
      check_bit("tx_frame", tx_frame, 1'b0);
      @(negedge sys_clk);
      check_bit("tx_frame", tx_frame, 1'b1);           // two cycles after strobe
      check_lane("tx_data", tx_data, p.ctrl);           // ctrl byte leads
      expect_frame(p, "single wr frame");
      last_wr = 1'b1;
   endtask

   task automatic test_tie_order();
      send_single(1'b0);   // read granted last
      send_pair();         // write first
      send_single(1'b1);
      send_pair();         // read first
      check_status("status", status, '0);
   endtask

   task automatic test_overflow();
      etx_pkt_pkg::etx_pkt_t     p [0:3];
      etx_ctrl_pkg::etx_status_t exp_st;
      int                        i;
      int                        n;
      for (i = 0; i < 4; i++)
         p[i] = random_pkt();
      fork
         begin
            strobe_ports(1'b1, p[0], 1'b0, '0);
            n = 0;
            while (!tx_frame && n < FRAME_TIMEOUT)
            begin
               @(negedge sys_clk);
               n++;
            end
            if (!tx_frame)
               report_timeout("frame before the burst");
            for (i = 1; i < 4; i++)
               strobe_ports(1'b1, p[i], 1'b0, '0);   // only p[1] finds room
         end
         begin
            expect_frame(p[0], "frame in flight");
            expect_frame(p[1], "accepted burst frame");
         end
      join
      expect_no_frame(FRAME_TIMEOUT);
      exp_st.wr_overflow = 1'b1;
      exp_st.rr_overflow = 1'b0;
      check_status("status", status, exp_st);
      last_wr = 1'b1;
   endtask

   task automatic test_soft_reset();
      soft_reset = 1'b1;
      wait_active(1'b0, 2 * HB_CYCLES, "tx_active to fall");
      check_bit("pll_reset", pll_reset, 1'b1);
      @(negedge sys_clk);                              // arbiter clears on next edge
      check_status("status", status, '0);
      strobe_ports(1'b1, random_pkt(), 1'b1, random_pkt());
      expect_no_frame(FRAME_TIMEOUT);
      soft_reset = 1'b0;
      wait_active(1'b1, LINK_TIMEOUT, "link to come back");
      settle_core_reset();
      last_wr = 1'b0;      // pointer back to its reset value
      send_pair();
   endtask

   initial
   begin
      sys_clk        = 1'b0;
      sys_nreset     = 1'b0;
      soft_reset     = 1'b0;
      lock_hold      = 1'b1;
      wr_strobe      = 1'b0;
      wr_pkt         = '0;
      rr_strobe      = 1'b0;
      rr_pkt         = '0;
      seed           = 32'h93c1_fec6;
      value_errors   = 0;
      timeout_errors = 0;
      other_errors   = 0;
      seq_idx        = 0;
      last_wr        = 1'b0;
      repeat (5) @(negedge sys_clk);
      test_link_up();
      test_single_write();
      test_tie_order();
      test_overflow();
      test_soft_reset();
      $display("summary: %0d value errors, %0d timeouts, %0d other errors",
               value_errors, timeout_errors, other_errors);
      if (value_errors + timeout_errors + other_errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule
